//--- source/fetch_pkg.sv
package fetch_pkg;

    localparam int ADDR_W      = 32;
    localparam int INST_W      = 32;
    localparam int FETCH_WORDS = 2;
    localparam int GROUP_BYTES = FETCH_WORDS * INST_W / 8;

    // axi read attributes for the instruction side
    localparam int AXI_ID_W = 4;
    localparam logic [AXI_ID_W-1:0] FETCH_ARID     = '0;
    localparam logic [1:0]          AXI_BURST_INCR = 2'b01;
    localparam logic [2:0]          AXI_SIZE_WORD  = 3'd2;
    localparam logic [2:0]          AXI_PROT_INSN  = 3'd4;
    localparam logic [1:0]          AXI_RESP_OKAY  = 2'b00;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [ADDR_W-1:0]   addr;
        logic [7:0]          len;
        logic [2:0]          size;
        logic [1:0]          burst;
        logic [2:0]          prot;
    } axi_ar_t;

    typedef struct packed {
        logic [INST_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    // addr is the raw pc, not aligned
    typedef struct packed {
        logic [ADDR_W-1:0]                  addr;
        logic [FETCH_WORDS-1:0][INST_W-1:0] words;
        logic                               err;
    } fetch_block_t;

    typedef struct packed {
        logic [ADDR_W-1:0]                  pc;
        logic [ADDR_W-1:0]                  pc_next;
        logic [FETCH_WORDS-1:0]             slot_valid;
        logic [FETCH_WORDS-1:0][INST_W-1:0] inst;
        logic                               err;
    } fetch_group_t;

endpackage

//--- source/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen
    import fetch_pkg::*;
#(
    parameter logic [ADDR_W-1:0] RESET_PC = 32'h1C000000
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  redirect_t         i_redirect_wb,
    input  redirect_t         i_redirect_ex,
    input  redirect_t         i_redirect_id,
    input  logic              i_advance,
    output logic [ADDR_W-1:0] o_pc,
    output logic              o_redirect
);

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] pc_seq;

    // next group starts at the aligned base, so a mid-group target falls back in line
    assign pc_seq = (pc & ~ADDR_W'(GROUP_BYTES - 1)) + ADDR_W'(GROUP_BYTES);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc <= RESET_PC;
        end else if (i_redirect_wb.valid) begin
            pc <= i_redirect_wb.target;
        end else if (i_redirect_ex.valid) begin
            pc <= i_redirect_ex.target;
        end else if (i_redirect_id.valid) begin
            pc <= i_redirect_id.target;
        end else if (i_advance) begin
            pc <= pc_seq;
        end
    end

    assign o_pc = pc;

    // any source marks the burst in flight stale
    assign o_redirect = i_redirect_wb.valid | i_redirect_ex.valid | i_redirect_id.valid;

endmodule

//--- source/fetch_axi_reader.sv
`timescale 1ns/1ps

module fetch_axi_reader
    import fetch_pkg::*;
(
    input  logic              aclk,
    input  logic              aresetn,
    input  logic [ADDR_W-1:0] i_pc,
    input  logic              i_redirect,
    input  logic              i_decode_full,
    input  logic              i_arready,
    input  axi_r_t            i_r,
    input  logic              i_rvalid,
    output axi_ar_t           o_ar,
    output logic              o_arvalid,
    output logic              o_rready,
    output logic              o_advance,
    output fetch_block_t      o_block,
    output logic              o_block_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    localparam int BEAT_W = (FETCH_WORDS > 1) ? $clog2(FETCH_WORDS) : 1;

    state_t                             state;
    logic [ADDR_W-1:0]                  fetch_pc;
    logic [BEAT_W-1:0]                  beat;
    logic [FETCH_WORDS-1:0][INST_W-1:0] words;
    logic                               err;
    logic                               stale;
    logic                               delivered;
    logic                               start;
    logic                               beat_fire;
    logic                               last_fire;

    // hold off one cycle after delivery so i_pc already shows the advance
    assign start     = (state == ST_IDLE) && !i_decode_full && !delivered;
    assign beat_fire = (state == ST_DATA) && i_rvalid;
    assign last_fire = beat_fire && i_r.last;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= ST_IDLE;
            beat      <= '0;
            stale     <= 1'b0;
            delivered <= 1'b0;
        end else begin
            delivered <= last_fire && !stale && !i_redirect;
            case (state)
                ST_IDLE: if (start) state <= ST_ADDR;
                ST_ADDR: if (i_arready) state <= ST_DATA;
                ST_DATA: if (last_fire) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
            // a redirect in the request cycle already makes the latched pc old
            if (start) begin
                stale <= i_redirect;
                beat  <= '0;
            end else begin
                if (i_redirect) stale <= 1'b1;
                if (beat_fire) beat <= beat + BEAT_W'(1);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            fetch_pc <= i_pc;
            err      <= 1'b0;
        end else if (beat_fire) begin
            words[beat] <= i_r.data;
            err         <= err | (i_r.resp != AXI_RESP_OKAY);
        end
    end

    assign o_ar = '{
        id:    FETCH_ARID,
        addr:  fetch_pc & ~ADDR_W'(GROUP_BYTES - 1),
        len:   8'(FETCH_WORDS - 1),
        size:  AXI_SIZE_WORD,
        burst: AXI_BURST_INCR,
        prot:  AXI_PROT_INSN
    };

    assign o_arvalid = (state == ST_ADDR);
    assign o_rready  = (state == ST_DATA);

    assign o_block = '{addr: fetch_pc, words: words, err: err};

    assign o_block_valid = delivered;
    assign o_advance     = delivered;

endmodule

//--- source/fetch_group_out.sv
`timescale 1ns/1ps

module fetch_group_out
    import fetch_pkg::*;
(
    input  logic         aclk,
    input  logic         aresetn,
    input  fetch_block_t i_block,
    input  logic         i_block_valid,
    output fetch_group_t o_group,
    output logic         o_group_valid
);

    localparam int OFS_LSB = $clog2(INST_W / 8);
    localparam int OFS_MSB = $clog2(GROUP_BYTES) - 1;

    logic [ADDR_W-1:0]        base;
    logic [OFS_MSB:OFS_LSB]   word_ofs;
    logic [FETCH_WORDS-1:0]   slot_valid;

    assign base     = i_block.addr & ~ADDR_W'(GROUP_BYTES - 1);
    assign word_ofs = i_block.addr[OFS_MSB:OFS_LSB];

    // slots below the entry word are not part of the instruction stream
    always_comb begin
        for (int s = 0; s < FETCH_WORDS; s++) begin
            slot_valid[s] = (s >= int'(word_ofs));
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_group_valid <= 1'b0;
        end else begin
            o_group_valid <= i_block_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_block_valid) begin
            o_group.pc         <= i_block.addr;
            o_group.pc_next    <= base + ADDR_W'(GROUP_BYTES);
            o_group.slot_valid <= slot_valid;
            o_group.inst       <= i_block.words;
            o_group.err        <= i_block.err;
        end
    end

endmodule

//--- source/fetch_frontend_top.sv
`timescale 1ns/1ps

module fetch_frontend_top
    import fetch_pkg::*;
#(
    parameter logic [ADDR_W-1:0] RESET_PC = 32'h1C000000
) (
    input  logic         aclk,
    input  logic         aresetn,
    input  redirect_t    i_redirect_wb,
    input  redirect_t    i_redirect_ex,
    input  redirect_t    i_redirect_id,
    input  logic         i_decode_full,
    output axi_ar_t      o_ar,
    output logic         o_arvalid,
    input  logic         i_arready,
    input  axi_r_t       i_r,
    input  logic         i_rvalid,
    output logic         o_rready,
    output fetch_group_t o_group,
    output logic         o_group_valid
);

    logic [ADDR_W-1:0] pc;
    logic              redirect;
    logic              advance;
    fetch_block_t      block;
    logic              block_valid;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_redirect_wb (i_redirect_wb),
        .i_redirect_ex (i_redirect_ex),
        .i_redirect_id (i_redirect_id),
        .i_advance     (advance),
        .o_pc          (pc),
        .o_redirect    (redirect)
    );

    fetch_axi_reader u_axi_reader (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_pc          (pc),
        .i_redirect    (redirect),
        .i_decode_full (i_decode_full),
        .i_arready     (i_arready),
        .i_r           (i_r),
        .i_rvalid      (i_rvalid),
        .o_ar          (o_ar),
        .o_arvalid     (o_arvalid),
        .o_rready      (o_rready),
        .o_advance     (advance),
        .o_block       (block),
        .o_block_valid (block_valid)
    );

    fetch_group_out u_group_out (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_block       (block),
        .i_block_valid (block_valid),
        .o_group       (o_group),
        .o_group_valid (o_group_valid)
    );

endmodule

//--- dv/axi_read_mem.sv
`timescale 1ns/1ps

module axi_read_mem
    import fetch_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h6156
) (
    input  logic    aclk,
    input  logic    aresetn,
    input  axi_ar_t i_ar,
    input  logic    i_arvalid,
    output logic    o_arready,
    output axi_r_t  o_r,
    output logic    o_rvalid,
    input  logic    i_rready
);

    logic [31:0]       rand_state;
    logic              busy;
    logic              arready_q = 1'b0;
    logic              rvalid_q = 1'b0;
    axi_r_t            r_q = '0;
    logic [ADDR_W-1:0] addr;
    logic [8:0]        beats_left;
    logic [1:0]        gap;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // data follows the byte address, bit 12 marks the error region
    function automatic axi_r_t beat_at(input logic [ADDR_W-1:0] a, input logic last);
        return '{data: a ^ 32'hA5A5_0000, resp: a[12] ? 2'd2 : 2'd0, last: last};
    endfunction

    always @(posedge aclk) begin
        if (!aresetn) begin
            rand_state <= SEED;
            busy       <= 1'b0;
            arready_q  <= 1'b0;
            rvalid_q   <= 1'b0;
            gap        <= 2'd0;
        end else begin
            rand_state <= lcg_next(rand_state);
            if (!busy) begin
                if (arready_q && i_arvalid) begin
                    arready_q  <= 1'b0;
                    busy       <= 1'b1;
                    addr       <= i_ar.addr;
                    beats_left <= {1'b0, i_ar.len} + 9'd1;
                    gap        <= rand_state[17:16];
                end else if (i_arvalid) begin
                    if (gap == 2'd0) arready_q <= 1'b1;
                    else gap <= gap - 2'd1;
                end
            end else if (rvalid_q) begin
                if (i_rready) begin
                    rvalid_q   <= 1'b0;
                    addr       <= addr + 32'd4;
                    beats_left <= beats_left - 9'd1;
                    gap        <= rand_state[17:16];
                    busy       <= (beats_left != 9'd1);
                end
            end else if (gap == 2'd0) begin
                rvalid_q <= 1'b1;
                r_q      <= beat_at(addr, beats_left == 9'd1);
            end else begin
                gap <= gap - 2'd1;
            end
        end
    end

    assign o_arready = arready_q;
    assign o_rvalid  = rvalid_q;
    assign o_r       = r_q;

endmodule

//--- dv/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend
    import fetch_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int SEQ_GROUPS   = 40;
    localparam int PHASE_GROUPS = 4;
    localparam int FULL_HOLD    = 40;
    // the full hold counts as groups of 20 cycles
    localparam int PLANNED_GROUPS = SEQ_GROUPS + 4 * PHASE_GROUPS + 2 + FULL_HOLD / 20;
    localparam logic [31:0]       RAND_SEED = 32'h6156;
    localparam logic [ADDR_W-1:0] BOOT_PC   = 32'h1C000000;

    logic         aclk;
    logic         aresetn;
    redirect_t    redirect_wb;
    redirect_t    redirect_ex;
    redirect_t    redirect_id;
    logic         decode_full;
    axi_ar_t      ar;
    logic         arvalid;
    logic         arready;
    axi_r_t       r;
    logic         rvalid;
    logic         rready;
    fetch_group_t group;
    logic         group_valid;

    logic [ADDR_W-1:0] exp_pcs[$];
    int                group_count   = 0;
    int                err_groups    = 0;
    int                full_groups   = 0;
    int                full_rises    = 0;
    logic              first_ar_done = 1'b0;
    logic              ar_wait       = 1'b0;
    logic              arvalid_prev  = 1'b0;
    logic              full_prev     = 1'b0;
    axi_ar_t           ar_prev;

    fetch_frontend_top i_dut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_redirect_wb (redirect_wb),
        .i_redirect_ex (redirect_ex),
        .i_redirect_id (redirect_id),
        .i_decode_full (decode_full),
        .o_ar          (ar),
        .o_arvalid     (arvalid),
        .i_arready     (arready),
        .i_r           (r),
        .i_rvalid      (rvalid),
        .o_rready      (rready),
        .o_group       (group),
        .o_group_valid (group_valid)
    );

    axi_read_mem #(
        .SEED (RAND_SEED)
    ) u_mem (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_ar      (ar),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_r       (r),
        .o_rvalid  (rvalid),
        .i_rready  (rready)
    );

    function automatic logic [INST_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        return a ^ 32'hA5A5_0000;
    endfunction

    // expected group for a fetch starting at pc
    function automatic fetch_group_t ref_group(input logic [ADDR_W-1:0] pc);
        fetch_group_t      g;
        logic [ADDR_W-1:0] base;
        base         = {pc[ADDR_W-1:3], 3'b000};
        g.pc         = pc;
        g.pc_next    = base + 32'd8;
        g.slot_valid = {1'b1, ~pc[2]};
        g.inst[0]    = mem_word(base);
        g.inst[1]    = mem_word(base + 32'd4);
        g.err        = base[12];
        return g;
    endfunction

    task automatic check(input logic [159:0] got, input logic [159:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic wait_groups(input int n);
        int target;
        target = group_count + n;
        wait (group_count >= target);
    endtask

    // pulse redirects while a burst is in its address phase
    task automatic redirect_in_flight(input redirect_t wb, input redirect_t ex, input redirect_t id);
        @(negedge aclk);
        while (!arvalid) @(negedge aclk);
        @(posedge aclk);
        redirect_wb <= wb;
        redirect_ex <= ex;
        redirect_id <= id;
        @(posedge aclk);
        redirect_wb <= '0;
        redirect_ex <= '0;
        redirect_id <= '0;
    endtask

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(PLANNED_GROUPS * 20 * CLK_PERIOD);
        $display("timeout: the run did not finish in time for %0d groups", PLANNED_GROUPS);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    always @(negedge aclk) begin : compare
        fetch_group_t expect_grp;
        axi_ar_t      first_ar;
        if (!aresetn) begin
            check(160'({arvalid, rready, group_valid}), 160'(0),
                  "valid or ready high during reset");
            exp_pcs.delete();
            exp_pcs.push_back(BOOT_PC);
        end else begin
            if (group_valid) begin
                check(160'(exp_pcs.size() != 0), 160'(1), "group with no expected pc");
                expect_grp = ref_group(exp_pcs.pop_front());
                check(160'(group), 160'(expect_grp), "fetch group");
                if (exp_pcs.size() == 0) exp_pcs.push_back(expect_grp.pc_next);
                if (group.err) err_groups++;
                if (decode_full) full_groups++;
                group_count++;
            end
            // writeback over execute over decode
            if (redirect_wb.valid || redirect_ex.valid || redirect_id.valid) begin
                exp_pcs.delete();
                if (redirect_wb.valid) exp_pcs.push_back(redirect_wb.target);
                else if (redirect_ex.valid) exp_pcs.push_back(redirect_ex.target);
                else exp_pcs.push_back(redirect_id.target);
            end
            if (arvalid && !first_ar_done) begin
                first_ar = '{id: 4'd0, addr: BOOT_PC, len: 8'd1, size: 3'd2,
                             burst: 2'd1, prot: 3'd4};
                check(160'(ar), 160'(first_ar), "first address phase");
                first_ar_done = 1'b1;
            end
            if (ar_wait) begin
                check(160'(arvalid), 160'(1), "o_arvalid dropped before o_arready");
                check(160'(ar), 160'(ar_prev), "o_ar changed while waiting");
            end
            if (decode_full && full_prev && arvalid && !arvalid_prev) full_rises++;
            ar_wait      = arvalid && !arready;
            ar_prev      = ar;
            arvalid_prev = arvalid;
            full_prev    = decode_full;
        end
    end

    initial begin
        aresetn     <= 1'b0;
        redirect_wb <= '0;
        redirect_ex <= '0;
        redirect_id <= '0;
        decode_full <= 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;

        wait_groups(SEQ_GROUPS);

        // entry word in slot 1, stale burst dropped
        redirect_in_flight('0, '{1'b1, 32'h1C00_0204}, '0);
        wait_groups(PHASE_GROUPS);
        redirect_in_flight('{1'b1, 32'h1C00_0400}, '{1'b1, 32'h1C00_0500},
                           '{1'b1, 32'h1C00_0600});
        wait_groups(PHASE_GROUPS);
        redirect_in_flight('0, '{1'b1, 32'h1C00_0700}, '{1'b1, 32'h1C00_0800});
        wait_groups(PHASE_GROUPS);

        @(posedge aclk);
        decode_full <= 1'b1;
        repeat (FULL_HOLD) @(posedge aclk);
        decode_full <= 1'b0;
        check(160'(full_groups > 1), 160'(0), "more than one group while decode full");
        check(160'(full_rises), 160'(0), "o_arvalid rose while decode full");
        wait_groups(2);

        check(160'(err_groups), 160'(0), "error bit outside the error region");
        redirect_in_flight('0, '0, '{1'b1, 32'h1C00_1000});
        wait_groups(PHASE_GROUPS);
        check(160'(err_groups), 160'(PHASE_GROUPS), "groups in the error region");

        $display("sim passed");
        $finish;
    end

endmodule

//--- fetch_frontend.f
source/fetch_pkg.sv
source/fetch_pc_gen.sv
source/fetch_axi_reader.sv
source/fetch_group_out.sv
source/fetch_frontend_top.sv
dv/axi_read_mem.sv
dv/tb_fetch_frontend.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= fetch_frontend.f
TOP       ?= tb_fetch_frontend
RTL_TOP   ?= fetch_frontend_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= sim passed
RTL_SRCS  ?= source/fetch_pkg.sv source/fetch_pc_gen.sv source/fetch_axi_reader.sv \
             source/fetch_group_out.sv source/fetch_frontend_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
